// File: receiver.f
+incdir+include
hw/receiver_pkg.sv
hw/pwm_pulse_timer.sv
hw/pulse_width_scaler.sv
hw/receiver.sv
bench/receiver_tb.sv

// File: bench/receiver_stimulus.txt
# widths in us for throttle yaw roll pitch aux1 aux2 mode (0 = no pulse), expected values in hex
# flag: 0 all update, 1 rejected channels hold, 2 yaw silent for 27 ms with signal_lost high
1000 1500 2000 1234 1450 1370 1000  5cd8 0000 2328 6d4c 0 f 0  0
950  2100 1500 2000 2000 1000 1286  5cd8 2328 0000 2328 5 b 2  0
2000 1000 1750 1250 1550 1630 2000  2328 5cd8 1194 6e6c 0 1 6  0
500  3000 1100 1900 1800 1200 1500  2328 5cd8 63e0 1c20 3 d 3  1
1600 1400 1300 1700 1000 2000 1143  0708 78f8 71f0 0e10 b 5 1  0
1500 0    1500 1500 1500 1500 1500  0000 78f8 0000 0000 0 0 3  2
1500 1100 1500 1500 1500 1500 1500  0000 63e0 0000 0000 0 0 3  0
2200 800  1234 1500 1450 1550 2200  2328 5cd8 6d4c 0000 0 0 6  0
1500 1500 1500 1500 2100 950  2100  0000 0000 0000 0000 5 b 6  0

// File: bench/receiver_tb.sv
/* RC receiver testbench
   Replays pulse frames from the stimulus file and checks the held channel values */
`timescale 1ns/1ps
`default_nettype none
`include "receiver_consts.svh"

module receiver_tb;

  localparam int N_CH      = 7;
  localparam int MAX_TESTS = 32;
  localparam int GAP_US    = 1000;
  localparam int LOSS_US   = 27000;

  logic        sys_clk;
  logic        rst_n;
  logic [6:0]  pwm;
  logic [14:0] throttle_val;
  logic [14:0] yaw_val;
  logic [14:0] roll_val;
  logic [14:0] pitch_val;
  logic [3:0]  aux1_val;
  logic [3:0]  aux2_val;
  logic [2:0]  mode_val;
  logic        signal_lost;

  // Test table from the stimulus file
  int          test_w    [MAX_TESTS][N_CH];
  logic [14:0] test_exp  [MAX_TESTS][N_CH];
  int          test_flag [MAX_TESTS];
  int          n_tests;
  logic [14:0] held [N_CH];

  int cycle_count;
  int cycle_limit;
  int fail_checks;
  int tests_passed;
  int tests_failed;

  receiver uut (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .throttle_pwm (pwm[0]),
    .yaw_pwm      (pwm[1]),
    .roll_pwm     (pwm[2]),
    .pitch_pwm    (pwm[3]),
    .aux1_pwm     (pwm[4]),
    .aux2_pwm     (pwm[5]),
    .mode_pwm     (pwm[6]),
    .throttle_val (throttle_val),
    .yaw_val      (yaw_val),
    .roll_val     (roll_val),
    .pitch_val    (pitch_val),
    .aux1_val     (aux1_val),
    .aux2_val     (aux2_val),
    .mode_val     (mode_val),
    .signal_lost  (signal_lost)
  );

  // 10 MHz clock
  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  // Run limit armed once the test table is known
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  // Timer accept window
  function automatic bit outside_window(input int w);
    return (w < `RX_MIN_ACCEPT_US) || (w > `RX_MAX_ACCEPT_US);
  endfunction

  // Sticks 15 bits, aux 4 bits, mode 3 bits
  function automatic int channel_bits(input int c);
    if (c < 4)
      return 15;
    else if (c < 6)
      return 4;
    return 3;
  endfunction

  function automatic string channel_name(input int c);
    case (c)
      0:       return "throttle_val";
      1:       return "yaw_val";
      2:       return "roll_val";
      3:       return "pitch_val";
      4:       return "aux1_val";
      5:       return "aux2_val";
      default: return "mode_val";
    endcase
  endfunction

  function automatic logic [14:0] channel_value(input int c);
    case (c)
      0:       return throttle_val;
      1:       return yaw_val;
      2:       return roll_val;
      3:       return pitch_val;
      4:       return aux1_val;
      5:       return aux2_val;
      default: return mode_val;
    endcase
  endfunction

  // Longest pulse plus the quiet gap
  function automatic int frame_cycles(input int t);
    int max_w;
    max_w = 0;
    for (int c = 0; c < N_CH; c++)
      if (test_w[t][c] > max_w)
        max_w = test_w[t][c];
    return (max_w + GAP_US) * `RX_CLKS_PER_US;
  endfunction

  // All pins rise together and each falls after its own width
  task automatic run_frame(input int t, output int cycles);
    logic [6:0] level;
    int         high_cycles;
    high_cycles = frame_cycles(t) - GAP_US * `RX_CLKS_PER_US;
    for (int k = 0; k < high_cycles; k++) begin
      for (int c = 0; c < N_CH; c++)
        level[c] = (k < test_w[t][c] * `RX_CLKS_PER_US);
      @(posedge sys_clk);
      pwm <= level;
    end
    repeat (GAP_US * `RX_CLKS_PER_US) begin
      @(posedge sys_clk);
      pwm <= '0;
    end
    cycles = frame_cycles(t);
  endtask

  // Compare one channel masked to its width
  task automatic check_channel(input int t, input int c, input logic [14:0] exp);
    logic [14:0] mask;
    logic [14:0] act;
    mask = 15'((1 << channel_bits(c)) - 1);
    act  = channel_value(c) & mask;
    if (act !== (exp & mask)) begin
      $display("ERROR test %0d: %s expected 0x%h, got 0x%h",
               t, channel_name(c), exp & mask, act);
      fail_checks++;
    end
  endtask

  task automatic check_lost(input int t, input logic exp);
    if (signal_lost !== exp) begin
      $display("ERROR test %0d: signal_lost expected 0x%h, got 0x%h", t, exp, signal_lost);
      fail_checks++;
    end
  endtask

  task automatic report_test(input int t, input int errs_before);
    if (fail_checks == errs_before) begin
      $display("test %0d passed", t);
      tests_passed++;
    end else begin
      $display("test %0d failed", t);
      tests_failed++;
    end
  endtask

  initial begin
    int               fd;
    int               n;
    int               fl;
    int               cycles;
    int               elapsed;
    int               errs_before;
    int               wt [N_CH];
    logic [14:0]      et [N_CH];
    logic [14:0]      exp;
    logic [8*256-1:0] text_line;
    rst_n       <= 1'b0;
    pwm         <= '0;
    cycle_limit = 0;
    n_tests     = 0;
    fd = $fopen("bench/receiver_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
    end else begin
      // Comment and blank lines fail the scan and are skipped
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        text_line = '0;
        n = $fgets(text_line, fd);
        n = $sscanf(text_line, "%d %d %d %d %d %d %d %h %h %h %h %h %h %h %d",
                    wt[0], wt[1], wt[2], wt[3], wt[4], wt[5], wt[6],
                    et[0], et[1], et[2], et[3], et[4], et[5], et[6], fl);
        if (n == 15) begin
          for (int c = 0; c < N_CH; c++) begin
            test_w[n_tests][c]   = wt[c];
            test_exp[n_tests][c] = et[c];
          end
          test_flag[n_tests] = fl;
          n_tests++;
        end
      end
      $fclose(fd);
    end

    // Reset, every frame and the loss runs with 20 % margin
    cycles = 32;
    for (int t = 0; t < n_tests; t++) begin
      if (test_flag[t] == 2)
        cycles += LOSS_US * `RX_CLKS_PER_US + frame_cycles(t);
      else
        cycles += frame_cycles(t);
    end
    cycle_limit = cycles * 6 / 5;

    repeat (16) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(negedge sys_clk);
    // Out of reset all values are zero and every channel is lost
    errs_before = fail_checks;
    for (int c = 0; c < N_CH; c++) begin
      held[c] = '0;
      check_channel(0, c, 15'h0);
    end
    check_lost(0, 1'b1);
    report_test(0, errs_before);

    for (int t = 0; t < n_tests; t++) begin
      errs_before = fail_checks;
      if (test_flag[t] == 2) begin
        // Same frame repeated until yaw has been silent long enough
        elapsed = 0;
        while (elapsed < LOSS_US * `RX_CLKS_PER_US) begin
          run_frame(t, cycles);
          elapsed += cycles;
        end
      end else begin
        run_frame(t, cycles);
      end
      @(negedge sys_clk);
      for (int c = 0; c < N_CH; c++) begin
        // A rejected pulse leaves the last good value
        if (test_flag[t] != 0 && outside_window(test_w[t][c]))
          exp = held[c];
        else
          exp = test_exp[t][c];
        held[c] = exp;
        check_channel(t + 1, c, exp);
      end
      check_lost(t + 1, test_flag[t] == 2);
      report_test(t + 1, errs_before);
    end

    if (n_tests == 0) begin
      $display("No tests found in the stimulus file");
      tests_failed++;
    end
    $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, fail_checks);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/receiver.sv
/* RC receiver decoder
   Seven PWM channels measured, scaled and held for the flight controller,
   with a summary flag for a channel that has gone quiet */
`timescale 1ns/1ps
`default_nettype none
`include "receiver_consts.svh"

module receiver (
  input  wire                      sys_clk,
  input  wire                      rst_n,
  input  wire                      throttle_pwm,
  input  wire                      yaw_pwm,
  input  wire                      roll_pwm,
  input  wire                      pitch_pwm,
  input  wire                      aux1_pwm,
  input  wire                      aux2_pwm,
  input  wire                      mode_pwm,
  output receiver_pkg::stick_val_t throttle_val,
  output receiver_pkg::stick_val_t yaw_val,
  output receiver_pkg::stick_val_t roll_val,
  output receiver_pkg::stick_val_t pitch_val,
  output receiver_pkg::aux_val_t   aux1_val,
  output receiver_pkg::aux_val_t   aux2_val,
  output receiver_pkg::mode_val_t  mode_val,
  output logic                     signal_lost
);

  // Channel order is throttle, yaw, roll, pitch, aux1, aux2, mode
  localparam int N_CH    = 7;
  localparam int N_STICK = 4;
  localparam int N_AUX   = 2;
  localparam int MODE_CH = N_STICK + N_AUX;

  logic [N_CH-1:0]            pwm_in;
  receiver_pkg::pulse_width_t width [N_CH];
  logic [N_CH-1:0]            width_valid;
  logic [N_CH-1:0]            val_valid;
  logic [N_CH-1:0]            lost;

  receiver_pkg::stick_val_t   stick_new  [N_STICK];
  receiver_pkg::stick_val_t   stick_hold [N_STICK];
  receiver_pkg::aux_val_t     aux_new    [N_AUX];
  receiver_pkg::aux_val_t     aux_hold   [N_AUX];
  receiver_pkg::mode_val_t    mode_new;

  assign pwm_in = {mode_pwm, aux2_pwm, aux1_pwm, pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};

  // One timer per channel
  for (genvar c = 0; c < N_CH; c++) begin : g_timer
    pwm_pulse_timer u_timer (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .pwm         (pwm_in[c]),
      .width       (width[c]),
      .width_valid (width_valid[c]),
      .lost        (lost[c])
    );
  end

  // Sticks
  for (genvar s = 0; s < N_STICK; s++) begin : g_stick
    pulse_width_scaler #(
      .val_t (receiver_pkg::stick_val_t),
      .RULE  (receiver_pkg::stick)
    ) u_scaler (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .width       (width[s]),
      .width_valid (width_valid[s]),
      .val         (stick_new[s]),
      .val_valid   (val_valid[s])
    );
  end

  // Aux switches
  for (genvar a = 0; a < N_AUX; a++) begin : g_aux
    pulse_width_scaler #(
      .val_t (receiver_pkg::aux_val_t),
      .RULE  (receiver_pkg::aux)
    ) u_scaler (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .width       (width[N_STICK+a]),
      .width_valid (width_valid[N_STICK+a]),
      .val         (aux_new[a]),
      .val_valid   (val_valid[N_STICK+a])
    );
  end

  // Flight mode
  pulse_width_scaler #(
    .val_t (receiver_pkg::mode_val_t),
    .RULE  (receiver_pkg::mode)
  ) u_mode_scaler (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .width       (width[MODE_CH]),
    .width_valid (width_valid[MODE_CH]),
    .val         (mode_new),
    .val_valid   (val_valid[MODE_CH])
  );

  // Hold registers keep the last good value per channel
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_STICK; i++)
        stick_hold[i] <= '0;
      for (int i = 0; i < N_AUX; i++)
        aux_hold[i] <= '0;
      mode_val <= '0;
    end else begin
      for (int i = 0; i < N_STICK; i++)
        if (val_valid[i])
          stick_hold[i] <= stick_new[i];
      for (int i = 0; i < N_AUX; i++)
        if (val_valid[N_STICK+i])
          aux_hold[i] <= aux_new[i];
      if (val_valid[MODE_CH])
        mode_val <= mode_new;
    end
  end

  assign throttle_val = stick_hold[0];
  assign yaw_val      = stick_hold[1];
  assign roll_val     = stick_hold[2];
  assign pitch_val    = stick_hold[3];
  assign aux1_val     = aux_hold[0];
  assign aux2_val     = aux_hold[1];

  // Any quiet channel raises the flag
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      signal_lost <= 1'b1;
    else
      signal_lost <= |lost;
  end

endmodule

`default_nettype wire

// File: hw/pulse_width_scaler.sv
/* Pulse width scaler
   Clamps an accepted pulse width and maps it to a stick, aux or mode value */
`timescale 1ns/1ps
`default_nettype none
`include "receiver_consts.svh"

module pulse_width_scaler #(
  parameter type                      val_t = receiver_pkg::stick_val_t,
  parameter receiver_pkg::scale_rule_e RULE = receiver_pkg::stick
) (
  input  wire                        sys_clk,
  input  wire                        rst_n,
  input  wire receiver_pkg::pulse_width_t width,
  input  wire                        width_valid,
  output val_t                       val,
  output logic                       val_valid
);

  localparam receiver_pkg::pulse_width_t LOW_US  = `RX_WIDTH_BITS'(`RX_LOW_US);
  localparam receiver_pkg::pulse_width_t HIGH_US = `RX_WIDTH_BITS'(`RX_HIGH_US);

  receiver_pkg::pulse_width_t clamped;
  val_t                       rule_val;

  // Clamp to the servo span
  always_comb begin
    if (width < LOW_US)
      clamped = LOW_US;
    else if (width > HIGH_US)
      clamped = HIGH_US;
    else
      clamped = width;
  end

  generate
    if (RULE == receiver_pkg::stick) begin : g_stick
      int offset;

      // Signed distance from mid in us
      assign offset = int'(clamped) - `RX_MID_US;

      // 18 counts per us gives +-9000
      always_comb begin
        rule_val = val_t'(offset * `RX_STICK_GAIN);
      end

    end else if (RULE == receiver_pkg::aux) begin : g_aux
      int offset;
      int steps;

      assign offset = int'(clamped) - `RX_MID_US;

      // Signed division truncates toward zero
      assign steps = offset / `RX_AUX_STEP_US;

      always_comb begin
        rule_val = val_t'(steps);
      end

    end else begin : g_mode
      int offset;
      int steps;

      // Mode counts up from the low end
      assign offset = int'(clamped) - `RX_LOW_US;
      assign steps  = offset / `RX_MODE_STEP_US;

      // Limit to the highest mode
      always_comb begin
        if (steps > `RX_MODE_MAX)
          rule_val = val_t'(`RX_MODE_MAX);
        else
          rule_val = val_t'(steps);
      end

      a_mode_max: assert property (@(posedge sys_clk) disable iff (!rst_n)
        val_valid |-> int'(val) <= `RX_MODE_MAX);
    end
  endgenerate

  // Valid strobe follows the width strobe
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      val_valid <= 1'b0;
    else
      val_valid <= width_valid;
  end

  // Result register
  always_ff @(posedge sys_clk) begin
    if (width_valid)
      val <= rule_val;
  end

endmodule

`default_nettype wire

// File: hw/pwm_pulse_timer.sv
/* PWM pulse timer
   Synchronizes one receiver channel, measures its high time in microseconds
   and flags the channel as lost after a long quiet period */
`timescale 1ns/1ps
`default_nettype none
`include "receiver_consts.svh"

module pwm_pulse_timer (
  input  wire                       sys_clk,
  input  wire                       rst_n,
  input  wire                       pwm,
  output logic [`RX_WIDTH_BITS-1:0] width,
  output logic                      width_valid,
  output logic                      lost
);

  localparam int PRE_W = $clog2(`RX_CLKS_PER_US + 1);
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`RX_CLKS_PER_US - 1);
  localparam logic [`RX_WIDTH_BITS-1:0] STUCK_US = `RX_WIDTH_BITS'(`RX_STUCK_HIGH_US);
  localparam logic [`RX_WIDTH_BITS-1:0] MIN_US = `RX_WIDTH_BITS'(`RX_MIN_ACCEPT_US);
  localparam logic [`RX_WIDTH_BITS-1:0] MAX_US = `RX_WIDTH_BITS'(`RX_MAX_ACCEPT_US);
  localparam int LOST_CYCLES = `RX_CLKS_PER_US * `RX_LOST_TIMEOUT_US;
  localparam int LOST_W = $clog2(LOST_CYCLES);
  localparam logic [LOST_W-1:0] LOST_LAST = LOST_W'(LOST_CYCLES - 1);

  logic [1:0]                sync_q;
  logic                      level_q;
  logic                      rise;
  logic                      fall;
  logic [PRE_W-1:0]          pre_cnt;
  logic [PRE_W-1:0]          pre_base;
  logic [`RX_WIDTH_BITS-1:0] us_cnt;
  logic [`RX_WIDTH_BITS-1:0] us_base;
  logic                      measuring;
  logic                      capture_q;
  logic [LOST_W-1:0]         lost_cnt;

  // Two-flop synchronizer, then the edge register
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= 2'b00;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], pwm};
      level_q <= sync_q[1];
    end
  end

  assign rise = sync_q[1] & ~level_q;
  assign fall = ~sync_q[1] & level_q;

  // First high cycle counts from zero
  assign pre_base = rise ? '0 : pre_cnt;
  assign us_base  = rise ? '0 : us_cnt;

  // Microsecond count of the high time
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt   <= '0;
      us_cnt    <= '0;
      measuring <= 1'b0;
    end else if (sync_q[1]) begin
      if (rise)
        measuring <= 1'b1;
      if (pre_base == PRE_LAST) begin
        pre_cnt <= '0;
        // Stuck high, drop this pulse and freeze the count
        if (us_base == STUCK_US)
          measuring <= 1'b0;
        else
          us_cnt <= us_base + 1'b1;
      end else begin
        pre_cnt <= pre_base + 1'b1;
        us_cnt  <= us_base;
      end
    end else begin
      measuring <= 1'b0;
    end
  end

  // Width latched at the falling edge
  always_ff @(posedge sys_clk) begin
    if (fall)
      width <= us_cnt;
  end

  // Range check one cycle after capture
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_q   <= 1'b0;
      width_valid <= 1'b0;
    end else begin
      capture_q   <= fall & measuring;
      width_valid <= capture_q && (width >= MIN_US) && (width <= MAX_US);
    end
  end

  // Loss timer, restarted by every accepted pulse
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      lost_cnt <= '0;
      lost     <= 1'b1;
    end else if (width_valid) begin
      lost_cnt <= '0;
      lost     <= 1'b0;
    end else if (lost_cnt == LOST_LAST) begin
      lost <= 1'b1;
    end else begin
      lost_cnt <= lost_cnt + 1'b1;
    end
  end

  a_valid_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
    width_valid |=> !width_valid);

  a_width_in_window: assert property (@(posedge sys_clk) disable iff (!rst_n)
    width_valid |-> (width >= MIN_US) && (width <= MAX_US));

endmodule

`default_nettype wire

// File: hw/receiver_pkg.sv
/* Receiver package
   Value types of the decoded channels and the scaler rule select */
`default_nettype none
`include "receiver_consts.svh"

package receiver_pkg;

  // Measured high time in microseconds
  typedef logic [`RX_WIDTH_BITS-1:0] pulse_width_t;

  // Stick value, -9000..9000
  typedef logic signed [14:0] stick_val_t;

  // Aux switch value, -5..5
  typedef logic signed [3:0] aux_val_t;

  // Flight mode, 0..6
  typedef logic [2:0] mode_val_t;

  // Scaling rule of one channel
  typedef enum logic [1:0] {
    stick,
    aux,
    mode
  } scale_rule_e;

endpackage

`default_nettype wire

// File: include/receiver_consts.svh
/* Receiver constants
   Clock rate, pulse limits, scaling constants and loss timeout shared by the PWM decoder */
`ifndef RECEIVER_CONSTS_SVH
`define RECEIVER_CONSTS_SVH

// sys_clk cycles per microsecond, 10 MHz clock
`define RX_CLKS_PER_US 10

// Measured pulse width in microseconds
`define RX_WIDTH_BITS 12

// Accept window, anything outside is a glitch
`define RX_MIN_ACCEPT_US 800
`define RX_MAX_ACCEPT_US 2200

// High time that aborts a measurement
`define RX_STUCK_HIGH_US 2500

// Scaling span of a standard servo pulse
`define RX_LOW_US  1000
`define RX_MID_US  1500
`define RX_HIGH_US 2000

// Stick counts per microsecond away from mid
`define RX_STICK_GAIN 18

// Aux and mode step sizes
`define RX_AUX_STEP_US  100
`define RX_MODE_STEP_US 143
`define RX_MODE_MAX     6

// Quiet time before a channel counts as lost
`define RX_LOST_TIMEOUT_US 25000

`endif
